/* include/tomasulo_defs.svh */
`ifndef TOMASULO_DEFS_SVH
`define TOMASULO_DEFS_SVH

// datapath and register file
`define TOMA_XLEN        32
`define TOMA_REG_COUNT   32
`define TOMA_REG_IDX_W   5

// reorder buffer, 8 entries addressed by a 3-bit tag
`define TOMA_ROB_DEPTH   8
`define TOMA_TAG_W       3

`define TOMA_STATIONS    4   // identical stations, all four ops

// execute cycles per opcode
`define TOMA_LAT_ADDSUB  1
`define TOMA_LAT_MUL     10
`define TOMA_LAT_DIV     40
`define TOMA_LAT_W       6   // holds 40

// reset value of register i, x0 stays zero
`define TOMA_REG_PRESET(i) ((i) == 0 ? 32'd0 : 32'(3 * (i) + 1))

`endif

/* logic/isa_pkg.sv */
package isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // operations handled by the core
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        op_add,
        op_sub,
        op_mul,
        op_div
    } op_e;

    //////////////////////////////////////////////////////////////////////
    // r-type field encodings
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_RTYPE    = 7'b0110011;

    localparam logic [2:0] F3_ADDSUBMUL = 3'b000;  // add, sub and mul share funct3
    localparam logic [2:0] F3_DIV       = 3'b100;

    localparam logic [6:0] F7_BASE      = 7'b0000000;  // add
    localparam logic [6:0] F7_SUB       = 7'b0100000;
    localparam logic [6:0] F7_MULDIV    = 7'b0000001;  // m extension

endpackage

/* logic/core_pkg.sv */
`include "tomasulo_defs.svh"

package core_pkg;

    // rob index doubles as the rename tag
    typedef logic [`TOMA_TAG_W-1:0] rob_tag_t;

    typedef logic [`TOMA_XLEN-1:0] word_t;

    // station life cycle
    typedef enum logic [1:0] {
        st_idle,  // free for dispatch
        st_wait,  // operands outstanding
        st_exec,  // latency counting
        st_done   // result ready, waiting for cdb grant
    } station_state_e;

endpackage

/* logic/rename_dispatch.sv */
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module rename_dispatch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    output logic                        instr_ready,
    input  logic [`TOMA_STATIONS-1:0]   station_busy,
    output logic [`TOMA_STATIONS-1:0]   alloc_sel,
    output isa_pkg::op_e                alloc_op,
    output core_pkg::rob_tag_t          alloc_tag_out,
    output logic                        src1_pending,
    output core_pkg::rob_tag_t          src1_tag,
    output core_pkg::word_t             src1_value,
    output logic                        src2_pending,
    output core_pkg::rob_tag_t          src2_tag,
    output core_pkg::word_t             src2_value,
    input  logic                        rob_full,
    input  core_pkg::rob_tag_t          rob_tail,
    output logic                        rob_alloc_valid,
    output logic [`TOMA_REG_IDX_W-1:0]  rob_alloc_dest,
    output core_pkg::rob_tag_t          look1_tag,
    output core_pkg::rob_tag_t          look2_tag,
    input  logic                        look1_ready,
    input  core_pkg::word_t             look1_value,
    input  logic                        look2_ready,
    input  core_pkg::word_t             look2_value,
    input  logic                        cdb_valid,
    input  core_pkg::rob_tag_t          cdb_tag,
    input  core_pkg::word_t             cdb_value,
    input  logic                        commit_valid,
    input  logic [`TOMA_REG_IDX_W-1:0]  commit_dest,
    input  core_pkg::word_t             commit_value,
    input  core_pkg::rob_tag_t          commit_tag
);

    logic [6:0]                  opcode;
    logic [6:0]                  funct7;
    logic [2:0]                  funct3;
    logic [`TOMA_REG_IDX_W-1:0]  rd;
    logic [`TOMA_REG_IDX_W-1:0]  rs1;
    logic [`TOMA_REG_IDX_W-1:0]  rs2;
    logic                        legal;
    logic                        do_disp;
    logic [`TOMA_STATIONS-1:0]   free;
    core_pkg::word_t             regfile [`TOMA_REG_COUNT];
    logic [`TOMA_REG_COUNT-1:0]  rat_busy;   // register renamed to a rob entry
    core_pkg::rob_tag_t          rat_tag [`TOMA_REG_COUNT];

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        legal    = 1'b0;
        alloc_op = isa_pkg::op_add;
        if (opcode == isa_pkg::OPC_RTYPE) begin
            if (funct3 == isa_pkg::F3_ADDSUBMUL) begin
                legal = 1'b1;
                case (funct7)
                    isa_pkg::F7_BASE:   alloc_op = isa_pkg::op_add;
                    isa_pkg::F7_SUB:    alloc_op = isa_pkg::op_sub;
                    isa_pkg::F7_MULDIV: alloc_op = isa_pkg::op_mul;
                    default:            legal = 1'b0;
                endcase
            end else if (funct3 == isa_pkg::F3_DIV && funct7 == isa_pkg::F7_MULDIV) begin
                legal    = 1'b1;
                alloc_op = isa_pkg::op_div;
            end
        end
    end

    // unknown encodings are still accepted, just never dispatched
    assign instr_ready = !rob_full && !(&station_busy);
    assign do_disp     = instr_valid && instr_ready && legal;

    assign free      = ~station_busy;
    assign alloc_sel = do_disp ? (free & -free) : '0;  // lowest idle station

    assign alloc_tag_out   = rob_tail;
    assign rob_alloc_valid = do_disp;
    assign rob_alloc_dest  = rd;

    //////////////////////////////////////////////////////////////////////
    // operand lookup
    //////////////////////////////////////////////////////////////////////

    assign look1_tag = rat_tag[rs1];
    assign look2_tag = rat_tag[rs2];

    // regfile, then cdb bypass, then rob, else wait on the tag
    function automatic void resolve(
        input  logic [`TOMA_REG_IDX_W-1:0] idx,
        input  logic                       rob_ready,
        input  core_pkg::word_t            rob_value,
        output logic                       pending,
        output core_pkg::rob_tag_t         tag,
        output core_pkg::word_t            value
    );
        tag     = rat_tag[idx];
        pending = 1'b0;
        value   = '0;
        if (!rat_busy[idx]) begin
            value = regfile[idx];
        end else if (cdb_valid && cdb_tag == rat_tag[idx]) begin
            value = cdb_value;
        end else if (rob_ready) begin
            value = rob_value;
        end else begin
            pending = 1'b1;
        end
    endfunction

    always_comb begin
        resolve(rs1, look1_ready, look1_value, src1_pending, src1_tag, src1_value);
        resolve(rs2, look2_ready, look2_value, src2_pending, src2_tag, src2_value);
    end

    //////////////////////////////////////////////////////////////////////
    // register file and rat
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `TOMA_REG_COUNT; i++) begin
                regfile[i] <= `TOMA_REG_PRESET(i);
            end
            rat_busy <= '0;
        end else begin
            if (commit_valid && commit_dest != '0) begin
                regfile[commit_dest] <= commit_value;
                // keep the mapping if a younger producer took the register
                if (rat_busy[commit_dest] && rat_tag[commit_dest] == commit_tag) begin
                    rat_busy[commit_dest] <= 1'b0;
                end
            end
            if (do_disp && rd != '0) begin  // dispatch wins over commit
                rat_busy[rd] <= 1'b1;
                rat_tag[rd]  <= rob_tail;
            end
        end
    end

endmodule

/* logic/reservation_station.sv */
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module reservation_station (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  isa_pkg::op_e        op,
    input  core_pkg::rob_tag_t  dest_tag,
    input  logic                src1_pending,
    input  core_pkg::rob_tag_t  src1_tag,
    input  core_pkg::word_t     src1_value,
    input  logic                src2_pending,
    input  core_pkg::rob_tag_t  src2_tag,
    input  core_pkg::word_t     src2_value,
    input  logic                cdb_valid,
    input  core_pkg::rob_tag_t  cdb_tag,
    input  core_pkg::word_t     cdb_value,
    input  logic                grant,
    output logic                busy,
    output logic                done,
    output core_pkg::rob_tag_t  result_tag,
    output core_pkg::word_t     result
);

    typedef logic [`TOMA_LAT_W-1:0] lat_t;

    core_pkg::station_state_e  state;
    isa_pkg::op_e              op_q;
    logic                      p1;
    logic                      p2;
    core_pkg::rob_tag_t        t1;
    core_pkg::rob_tag_t        t2;
    core_pkg::word_t           v1;
    core_pkg::word_t           v2;
    lat_t                      lat_cnt;
    lat_t                      lat_start;
    core_pkg::word_t           alu_out;

    // execute unit, result taken at start, latency only delays done
    always_comb begin
        case (op_q)
            isa_pkg::op_add: begin
                alu_out   = v1 + v2;
                lat_start = lat_t'(`TOMA_LAT_ADDSUB - 1);
            end
            isa_pkg::op_sub: begin
                alu_out   = v1 - v2;
                lat_start = lat_t'(`TOMA_LAT_ADDSUB - 1);
            end
            isa_pkg::op_mul: begin
                alu_out   = v1 * v2;  // low half
                lat_start = lat_t'(`TOMA_LAT_MUL - 1);
            end
            default: begin
                alu_out   = (v2 == '0) ? '1 : v1 / v2;  // unsigned, x/0 is all ones
                lat_start = lat_t'(`TOMA_LAT_DIV - 1);
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and latency counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= core_pkg::st_idle;
            lat_cnt <= '0;
        end else begin
            case (state)
                core_pkg::st_idle: if (load) state <= core_pkg::st_wait;
                core_pkg::st_wait: begin
                    if (!p1 && !p2) begin  // both operands held since last edge
                        state   <= core_pkg::st_exec;
                        lat_cnt <= lat_start;
                    end
                end
                core_pkg::st_exec: begin
                    if (lat_cnt == '0) state <= core_pkg::st_done;
                    else lat_cnt <= lat_cnt - lat_t'(1);
                end
                default: if (grant) state <= core_pkg::st_idle;  // st_done
            endcase
        end
    end

    // operand capture, either from dispatch or snooped off the cdb
    always_ff @(posedge clk) begin
        if (load) begin
            op_q       <= op;
            result_tag <= dest_tag;
            p1         <= src1_pending;
            t1         <= src1_tag;
            v1         <= src1_value;
            p2         <= src2_pending;
            t2         <= src2_tag;
            v2         <= src2_value;
        end else if (state == core_pkg::st_wait) begin
            if (cdb_valid && p1 && cdb_tag == t1) begin
                p1 <= 1'b0;
                v1 <= cdb_value;
            end
            if (cdb_valid && p2 && cdb_tag == t2) begin
                p2 <= 1'b0;
                v2 <= cdb_value;
            end
            if (!p1 && !p2) result <= alu_out;
        end
    end

    assign busy = state != core_pkg::st_idle;
    assign done = state == core_pkg::st_done;

endmodule

/* logic/cdb_arbiter.sv */
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module cdb_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`TOMA_STATIONS-1:0]  done,
    input  core_pkg::rob_tag_t         tag [`TOMA_STATIONS],
    input  core_pkg::word_t            result [`TOMA_STATIONS],
    output logic [`TOMA_STATIONS-1:0]  grant,
    output logic                       cdb_valid,
    output core_pkg::rob_tag_t         cdb_tag,
    output core_pkg::word_t            cdb_value
);

    localparam int SEL_W = $clog2(`TOMA_STATIONS);

    logic [SEL_W-1:0] sel;

    // fixed priority, station 0 first
    assign grant = done & -done;

    always_comb begin
        sel = '0;
        for (int i = `TOMA_STATIONS - 1; i >= 0; i--) begin
            if (done[i]) sel = SEL_W'(i);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // broadcast register, one cycle behind the grant
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) cdb_valid <= 1'b0;
        else cdb_valid <= |done;  // low when nobody was granted
    end

    always_ff @(posedge clk) begin
        cdb_tag   <= tag[sel];
        cdb_value <= result[sel];
    end

endmodule

/* logic/reorder_buffer.sv */
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module reorder_buffer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alloc_valid,
    input  logic [`TOMA_REG_IDX_W-1:0]  alloc_dest,
    output core_pkg::rob_tag_t          tail,
    output logic                        full,
    input  logic                        cdb_valid,
    input  core_pkg::rob_tag_t          cdb_tag,
    input  core_pkg::word_t             cdb_value,
    input  core_pkg::rob_tag_t          look1_tag,
    input  core_pkg::rob_tag_t          look2_tag,
    output logic                        look1_ready,
    output core_pkg::word_t             look1_value,
    output logic                        look2_ready,
    output core_pkg::word_t             look2_value,
    output logic                        commit_valid,
    output logic [`TOMA_REG_IDX_W-1:0]  commit_dest,
    output core_pkg::word_t             commit_value,
    output core_pkg::rob_tag_t          commit_tag
);

    localparam int CNT_W = $clog2(`TOMA_ROB_DEPTH + 1);

    core_pkg::rob_tag_t          head;
    logic [CNT_W-1:0]            count;
    logic [`TOMA_ROB_DEPTH-1:0]  written;  // result arrived from cdb
    logic [`TOMA_REG_IDX_W-1:0]  dest_q [`TOMA_ROB_DEPTH];
    core_pkg::word_t             value_q [`TOMA_ROB_DEPTH];

    assign full = count == CNT_W'(`TOMA_ROB_DEPTH);

    // written is only ever set on a live entry, so no count check here
    assign commit_valid = written[head];
    assign commit_dest  = dest_q[head];
    assign commit_value = value_q[head];
    assign commit_tag   = head;

    assign look1_ready = written[look1_tag];
    assign look1_value = value_q[look1_tag];
    assign look2_ready = written[look2_tag];
    assign look2_value = value_q[look2_tag];

    //////////////////////////////////////////////////////////////////////
    // pointers and flags
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            written <= '0;
        end else begin
            if (cdb_valid) written[cdb_tag] <= 1'b1;
            if (commit_valid) begin
                written[head] <= 1'b0;
                head          <= core_pkg::rob_tag_t'(head + 1);  // depth is a power of two
            end
            if (alloc_valid) begin
                written[tail] <= 1'b0;
                tail          <= core_pkg::rob_tag_t'(tail + 1);
            end
            count <= count + CNT_W'(alloc_valid) - CNT_W'(commit_valid);
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_valid) dest_q[tail] <= alloc_dest;
        if (cdb_valid) value_q[cdb_tag] <= cdb_value;
    end

endmodule

/* logic/tomasulo_core.sv */
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module tomasulo_core (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        instr_valid,
    input  logic [31:0]                 instr,
    output logic                        instr_ready,
    output logic                        commit_valid,
    output logic [`TOMA_REG_IDX_W-1:0]  commit_dest,
    output core_pkg::word_t             commit_value
);

    // dispatch bus
    logic [`TOMA_STATIONS-1:0]   station_busy;
    logic [`TOMA_STATIONS-1:0]   alloc_sel;
    isa_pkg::op_e                alloc_op;
    core_pkg::rob_tag_t          alloc_tag;
    logic                        src1_pending;
    core_pkg::rob_tag_t          src1_tag;
    core_pkg::word_t             src1_value;
    logic                        src2_pending;
    core_pkg::rob_tag_t          src2_tag;
    core_pkg::word_t             src2_value;

    // rob side
    logic                        rob_full;
    core_pkg::rob_tag_t          rob_tail;
    logic                        rob_alloc_valid;
    logic [`TOMA_REG_IDX_W-1:0]  rob_alloc_dest;
    core_pkg::rob_tag_t          look1_tag;
    core_pkg::rob_tag_t          look2_tag;
    logic                        look1_ready;
    core_pkg::word_t             look1_value;
    logic                        look2_ready;
    core_pkg::word_t             look2_value;
    core_pkg::rob_tag_t          commit_tag;

    // cdb side
    logic [`TOMA_STATIONS-1:0]   st_done;
    core_pkg::rob_tag_t          st_tag [`TOMA_STATIONS];
    core_pkg::word_t             st_result [`TOMA_STATIONS];
    logic [`TOMA_STATIONS-1:0]   grant;
    logic                        cdb_valid;
    core_pkg::rob_tag_t          cdb_tag;
    core_pkg::word_t             cdb_value;

    rename_dispatch rename_dispatch_i (
        .clk, .rst, .instr_valid, .instr, .instr_ready,
        .station_busy, .alloc_sel, .alloc_op, .alloc_tag_out(alloc_tag),
        .src1_pending, .src1_tag, .src1_value,
        .src2_pending, .src2_tag, .src2_value,
        .rob_full, .rob_tail, .rob_alloc_valid, .rob_alloc_dest,
        .look1_tag, .look2_tag, .look1_ready, .look1_value, .look2_ready, .look2_value,
        .cdb_valid, .cdb_tag, .cdb_value,
        .commit_valid, .commit_dest, .commit_value, .commit_tag
    );

    reorder_buffer reorder_buffer_i (
        .clk, .rst, .alloc_valid(rob_alloc_valid), .alloc_dest(rob_alloc_dest),
        .tail(rob_tail), .full(rob_full), .cdb_valid, .cdb_tag, .cdb_value,
        .look1_tag, .look2_tag, .look1_ready, .look1_value, .look2_ready, .look2_value,
        .commit_valid, .commit_dest, .commit_value, .commit_tag
    );

    cdb_arbiter cdb_arbiter_i (
        .clk, .rst, .done(st_done), .tag(st_tag), .result(st_result),
        .grant, .cdb_valid, .cdb_tag, .cdb_value
    );

    //////////////////////////////////////////////////////////////////////
    // station pool, payload shared, load by one-hot select
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `TOMA_STATIONS; i++) begin : g_station
        reservation_station station_i (
            .clk, .rst, .load(alloc_sel[i]), .op(alloc_op), .dest_tag(alloc_tag),
            .src1_pending, .src1_tag, .src1_value,
            .src2_pending, .src2_tag, .src2_value,
            .cdb_valid, .cdb_tag, .cdb_value, .grant(grant[i]),
            .busy(station_busy[i]), .done(st_done[i]),
            .result_tag(st_tag[i]), .result(st_result[i])
        );
    end

endmodule

/* testbench/tomasulo_tb.sv */
`timescale 1ns/100ps
`include "tomasulo_defs.svh"

module tomasulo_tb;

    localparam int N_BASIC  = 4;
    localparam int N_CHAIN  = 6;
    localparam int N_ORDER  = 9;
    localparam int N_RANDOM = 40;
    localparam int N_X0     = 4;
    localparam int N_INSTR  = N_BASIC + N_CHAIN + N_ORDER + N_RANDOM + N_X0 + 1;  // + addi
    localparam int TIMEOUT_CYCLES = N_INSTR * 60 + 400;  // 400 for reset, gaps, drains

    logic                        clk;
    logic                        rst;
    logic                        instr_valid;
    logic [31:0]                 instr;
    logic                        instr_ready;
    logic                        commit_valid;
    logic [`TOMA_REG_IDX_W-1:0]  commit_dest;
    logic [`TOMA_XLEN-1:0]       commit_value;

    isa_pkg::op_e                drv_op;     // op behind the word on instr
    logic                        drv_legal;  // low for words the core drops
    logic [`TOMA_XLEN-1:0]       model_reg [`TOMA_REG_COUNT];  // program order view
    logic [`TOMA_REG_IDX_W-1:0]  exp_dest [256];
    logic [`TOMA_XLEN-1:0]       exp_value [256];
    int                          wr_ptr;   // accepted legal instructions
    int                          rd_ptr;   // commits seen
    logic                        pop_req;
    int                          stall_cycles;
    int                          mismatch_errors = 0;
    int                          other_errors = 0;
    integer                      seed;
    string                       test_name;

    tomasulo_core dut_i (
        .clk, .rst, .instr_valid, .instr, .instr_ready,
        .commit_valid, .commit_dest, .commit_value
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns
    end

    //////////////////////////////////////////////////////////////////////
    // encoder and reference arithmetic
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] encode_rtype(input isa_pkg::op_e op,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
        logic [6:0] f7;
        logic [2:0] f3;
        f3 = isa_pkg::F3_ADDSUBMUL;
        case (op)
            isa_pkg::op_add: f7 = isa_pkg::F7_BASE;
            isa_pkg::op_sub: f7 = isa_pkg::F7_SUB;
            isa_pkg::op_mul: f7 = isa_pkg::F7_MULDIV;
            default: begin
                f7 = isa_pkg::F7_MULDIV;
                f3 = isa_pkg::F3_DIV;
            end
        endcase
        return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_RTYPE};
    endfunction

    function automatic logic [31:0] model_result(input isa_pkg::op_e op,
            input logic [31:0] a, input logic [31:0] b);
        case (op)
            isa_pkg::op_add: return a + b;
            isa_pkg::op_sub: return a - b;
            isa_pkg::op_mul: return a * b;          // low 32 bits
            default:         return (b == 0) ? 32'hffff_ffff : a / b;  // unsigned
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // monitor samples everything mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [31:0] v;
        if (rst) begin
            for (int i = 0; i < `TOMA_REG_COUNT; i++) model_reg[i] = `TOMA_REG_PRESET(i);
            wr_ptr       <= 0;
            pop_req      <= 1'b0;
            stall_cycles = 0;
        end else begin
            pop_req <= commit_valid;  // head advances on the next rising edge
            if (instr_valid && !instr_ready) stall_cycles++;
            if (instr_valid && instr_ready && drv_legal) begin  // transfers at next edge
                v = model_result(drv_op, model_reg[instr[19:15]], model_reg[instr[24:20]]);
                if (instr[11:7] != 0) model_reg[instr[11:7]] = v;  // x0 stays zero
                exp_dest[wr_ptr]  <= instr[11:7];
                exp_value[wr_ptr] <= v;
                wr_ptr            <= wr_ptr + 1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) rd_ptr <= 0;
        else if (pop_req) rd_ptr <= rd_ptr + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    idle_after_reset: assert property (@(negedge clk) disable iff (rst)
        (wr_ptr == 0) |-> (!commit_valid && instr_ready))
        else begin
            other_errors++;
            $display("core not idle and ready after reset");
        end

    commit_expected: assert property (@(negedge clk) disable iff (rst)
        commit_valid |-> (rd_ptr < wr_ptr))
        else begin
            other_errors++;
            $display("commit seen in %s with no instruction outstanding", test_name);
        end

    commit_in_order: assert property (@(negedge clk) disable iff (rst)
        (commit_valid && rd_ptr < wr_ptr) |->
            (commit_dest == exp_dest[rd_ptr] && commit_value == exp_value[rd_ptr]))
        else begin
            mismatch_errors++;
            $display("mismatch %s: expected x%0d = %h, actual x%0d = %h", test_name,
                exp_dest[rd_ptr], exp_value[rd_ptr], commit_dest, commit_value);
        end

    rob_bound: assert property (@(negedge clk) disable iff (rst)
        (wr_ptr - rd_ptr) <= `TOMA_ROB_DEPTH)
        else begin
            other_errors++;
            $display("more than %0d instructions in flight", `TOMA_ROB_DEPTH);
        end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // holds the word until the core takes it
    task automatic drive_word(input logic [31:0] word, input isa_pkg::op_e op,
            input logic legal);
        logic took;
        instr       <= word;
        drv_op      <= op;
        drv_legal   <= legal;
        instr_valid <= 1'b1;
        took = 1'b0;
        while (!took) begin
            @(negedge clk);
            took = instr_ready;
            @(posedge clk);
        end
        instr_valid <= 1'b0;
    endtask

    task automatic send_op(input isa_pkg::op_e op, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2);
        drive_word(encode_rtype(op, rd, rs1, rs2), op, 1'b1);
    endtask

    task automatic wait_drain();
        while (rd_ptr != wr_ptr) @(negedge clk);
        @(posedge clk);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] g;
        isa_pkg::op_e op;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        drv_op      = isa_pkg::op_add;
        drv_legal   = 1'b0;
        seed        = 32'h352fc389;
        test_name   = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        idle_cycles(4);  // idle window for the post reset check

        test_name = "independent_addsub";
        send_op(isa_pkg::op_add, 5'd10, 5'd1, 5'd2);
        send_op(isa_pkg::op_sub, 5'd11, 5'd3, 5'd4);
        send_op(isa_pkg::op_add, 5'd12, 5'd5, 5'd6);
        send_op(isa_pkg::op_sub, 5'd13, 5'd8, 5'd7);
        wait_drain();

        test_name = "muldiv_chain";
        send_op(isa_pkg::op_mul, 5'd3, 5'd1, 5'd2);
        send_op(isa_pkg::op_div, 5'd4, 5'd3, 5'd2);
        send_op(isa_pkg::op_mul, 5'd5, 5'd4, 5'd3);
        send_op(isa_pkg::op_div, 5'd6, 5'd5, 5'd0);  // divide by zero
        send_op(isa_pkg::op_sub, 5'd7, 5'd6, 5'd1);
        send_op(isa_pkg::op_add, 5'd8, 5'd7, 5'd4);
        wait_drain();

        test_name = "div_then_adds";
        send_op(isa_pkg::op_div, 5'd9, 5'd10, 5'd11);
        send_op(isa_pkg::op_add, 5'd14, 5'd13, 5'd12);
        send_op(isa_pkg::op_add, 5'd15, 5'd9, 5'd14);  // waits on the div
        send_op(isa_pkg::op_add, 5'd16, 5'd1, 5'd2);
        send_op(isa_pkg::op_sub, 5'd17, 5'd3, 5'd4);
        send_op(isa_pkg::op_add, 5'd18, 5'd5, 5'd6);
        send_op(isa_pkg::op_sub, 5'd19, 5'd7, 5'd8);
        send_op(isa_pkg::op_add, 5'd23, 5'd16, 5'd12);  // rob full behind the div
        send_op(isa_pkg::op_sub, 5'd24, 5'd17, 5'd14);  // held until the div commits
        wait_drain();

        test_name = "random_stream";
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            g = $random(seed);
            case (r[2:0])
                3'd5:    op = isa_pkg::op_mul;
                3'd6:    op = isa_pkg::op_add;
                3'd7:    op = isa_pkg::op_sub;
                default: op = isa_pkg::op_div;  // mostly long divs
            endcase
            if (n == N_RANDOM / 2) drive_word(32'h00a08093, isa_pkg::op_add, 1'b0);  // addi
            send_op(op, g[4:0], g[9:5], g[14:10]);
            idle_cycles(int'(g[17:16]));
        end
        wait_drain();

        test_name = "x0_writes";
        send_op(isa_pkg::op_add, 5'd0, 5'd1, 5'd2);   // still commits
        send_op(isa_pkg::op_mul, 5'd20, 5'd0, 5'd5);
        send_op(isa_pkg::op_add, 5'd21, 5'd0, 5'd0);
        send_op(isa_pkg::op_sub, 5'd22, 5'd1, 5'd0);
        wait_drain();

        assert (stall_cycles > 0)
            else begin
                other_errors++;
                $display("instr_ready never dropped while instructions were offered");
            end

        $display("%0d instructions committed, %0d mismatch errors, %0d other errors",
            rd_ptr, mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout in %s, %0d of %0d accepted instructions committed",
            test_name, rd_ptr, wr_ptr);
        $display("Test failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+include
logic/isa_pkg.sv
logic/core_pkg.sv
logic/rename_dispatch.sv
logic/reservation_station.sv
logic/cdb_arbiter.sv
logic/reorder_buffer.sv
logic/tomasulo_core.sv
testbench/tomasulo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the Tomasulo core testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=tomasulo_sim

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tomasulo_tb -o "$SIM"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$LOG"; then
    exit 0
fi
exit 1
